// ==== dv/fmap_buffer_checker.sv ====
`timescale 1ns/1ps

module fmap_buffer_checker (
    input logic clk,
    input logic rst,
    input logic pool_busy,
    input logic pool_done
);
    import fmap_geom_pkg::*;

    int busy_len; // length of the current busy stretch.

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            busy_len <= 0;
        end
        else
        begin
            busy_len <= pool_busy ? busy_len + 1 : 0;
        end
    end

    a_done_single: assert property (@(posedge clk) disable iff (!rst)
        pool_done |=> !pool_done) else $error("pool_done held longer than one cycle");

    a_busy_bound: assert property (@(posedge clk) disable iff (!rst)
        pool_busy |-> busy_len < POOL_SIZE) else $error("pool_busy held too long");

    a_busy_length: assert property (@(posedge clk) disable iff (!rst)
        $fell(pool_busy) |-> busy_len == POOL_SIZE) else $error("pool_busy ended early");

    a_done_after_busy: assert property (@(posedge clk) disable iff (!rst)
        $fell(pool_busy) |-> pool_done) else $error("no pool_done after busy fell");

    a_exclusive: assert property (@(posedge clk) disable iff (!rst)
        !(pool_busy && pool_done)) else $error("pool_busy and pool_done both high");

endmodule

bind fmap_buffer fmap_buffer_checker u_checker (
    .clk       (clk),
    .rst       (rst),
    .pool_busy (pool_busy),
    .pool_done (pool_done)
);

// ==== dv/fmap_buffer_tb.sv ====
`timescale 1ns/1ps

module fmap_buffer_tb;
    import fmap_geom_pkg::*;
    import act_types_pkg::*;

    localparam int N_STORES   = NUM_CH * MAP_SIZE;
    localparam int N_SWEEP    = MAP_SIZE / 2;
    localparam int N_RAND_RD  = 300;
    localparam int N_POOL_RD  = POOL_SIZE / 2;
    localparam int N_READS    = N_SWEEP + 2 * N_RAND_RD + N_POOL_RD;
    localparam int TIMEOUT_NS = (N_STORES + N_READS + 2 * 200 + 100) * 20;

    logic                  clk;
    logic                  rst;
    store_req_t            store;
    read_req_t             rd_req;
    logic                  pool_start;
    rd_pair_t [NUM_CH-1:0] rd_data;
    logic                  pool_busy;
    logic                  pool_done;

    act_t        model_mem [NUM_CH][MAP_SIZE];
    rd_pair_t    model_rd  [NUM_CH]; // last loaded pair per channel.
    logic [31:0] rng;

    fmap_buffer u_dut (
        .clk        (clk),
        .rst        (rst),
        .store      (store),
        .rd_req     (rd_req),
        .pool_start (pool_start),
        .rd_data    (rd_data),
        .pool_busy  (pool_busy),
        .pool_done  (pool_done)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw(output logic [31:0] r);
        rng = xorshift32(rng);
        r   = rng;
    endtask

    // biased store result, clipped to int8.
    function automatic act_t clip_sum(act_t a, act_t b);
        int s;
        s = int'(a) + int'(b);
        if (s > 127)
        begin
            s = 127;
        end
        else if (s < -128)
        begin
            s = -128;
        end
        return act_t'(s);
    endfunction

    // extremes show up about one time in four.
    function automatic act_t pick_act(logic [31:0] r);
        case (r[2:0])
            3'd0:    return 8'sd127;
            3'd1:    return -8'sd128;
            default: return act_t'(r[15:8]);
        endcase
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic report_mismatch(string msg);
        $display("Mismatch at time %0t: %s", $time, msg);
        $display("*** FAILED ***");
        $fatal(1, "value check failed");
    endtask

    task automatic check_rd();
        for (int c = 0; c < NUM_CH; c++)
        begin
            assert (rd_data[c] == model_rd[c])
            else
            begin
                report_mismatch($sformatf("ch %0d rd_data %h, expected %h",
                                          c, rd_data[c], model_rd[c]));
            end
        end
    endtask

    task automatic check_flags(logic busy_exp, logic done_exp, string what);
        assert (pool_busy == busy_exp && pool_done == done_exp)
        else
        begin
            report_mismatch($sformatf("%s busy %b done %b, expected %b %b",
                                      what, pool_busy, pool_done, busy_exp, done_exp));
        end
    endtask

    task automatic do_store(int ch, int addr);
        logic [31:0] r;
        act_t        value;
        act_t        bias;
        draw(r);
        value       = pick_act(r);
        bias        = pick_act(r >> 16);
        store.valid = 1'b1;
        store.ch    = 3'(ch);
        store.addr  = ADDR_W'(addr);
        store.value = value;
        store.bias  = bias;
        model_mem[ch][addr] = clip_sum(value, bias);
        tick();
        store.valid = 1'b0;
    endtask

    task automatic do_read(logic [NUM_CH-1:0] mask, int a1, int a2);
        rd_req.load  = mask;
        rd_req.addr1 = ADDR_W'(a1);
        rd_req.addr2 = ADDR_W'(a2);
        for (int c = 0; c < NUM_CH; c++)
        begin
            if (mask[c])
            begin
                model_rd[c].data1 = model_mem[c][a1];
                model_rd[c].data2 = model_mem[c][a2];
            end
        end
        tick();
        rd_req.load = '0;
        check_rd(); // unmasked channels must hold.
    endtask

    task automatic rand_read();
        logic [31:0] r1;
        logic [31:0] r2;
        draw(r1);
        draw(r2);
        do_read(r1[NUM_CH-1:0], int'(r1[31:16]) % MAP_SIZE, int'(r2[15:0]) % MAP_SIZE);
    endtask

    // 2x2 max with relu, compacted to address k.
    task automatic model_pool();
        act_t snap [NUM_CH][MAP_SIZE];
        act_t m;
        act_t v;
        int   base;
        snap = model_mem;
        for (int c = 0; c < NUM_CH; c++)
        begin
            for (int k = 0; k < POOL_SIZE; k++)
            begin
                base = 2 * MAP_W * (k / POOL_W) + 2 * (k % POOL_W);
                m    = -8'sd128;
                for (int dy = 0; dy < 2; dy++)
                begin
                    for (int dx = 0; dx < 2; dx++)
                    begin
                        v = snap[c][base + dy * MAP_W + dx];
                        m = (v > m) ? v : m;
                    end
                end
                model_mem[c][k] = (m < 0) ? act_t'(0) : m;
            end
        end
    endtask

    task automatic run_pool();
        int          busy_cycles;
        logic [31:0] r;
        busy_cycles = 0;
        pool_start  = 1'b1;
        tick();
        pool_start = 1'b0;
        check_flags(1'b1, 1'b0, "pool start");
        while (pool_busy)
        begin
            busy_cycles++;
            draw(r); // traffic the banks must drop.
            store.valid  = 1'b1;
            store.ch     = r[2:0];
            store.addr   = ADDR_W'(int'(r[31:16]) % MAP_SIZE);
            store.value  = act_t'(r[15:8]);
            store.bias   = '0;
            rd_req.load  = r[10:3];
            rd_req.addr1 = ADDR_W'(int'(r[27:12]) % MAP_SIZE);
            rd_req.addr2 = ADDR_W'(int'(r[19:4]) % MAP_SIZE);
            tick();
            check_rd();
        end
        store.valid = 1'b0;
        rd_req.load = '0;
        assert (busy_cycles == POOL_SIZE)
        else
        begin
            report_mismatch($sformatf("pool_busy high %0d cycles, expected %0d",
                                      busy_cycles, POOL_SIZE));
        end
        check_flags(1'b0, 1'b1, "pool end");
        tick();
        check_flags(1'b0, 1'b0, "after done");
        model_pool();
    endtask

    initial
    begin
        #(TIMEOUT_NS);
        $display("Timeout: test sequence still running after %0d ns", TIMEOUT_NS);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        clk        = 1'b0;
        rst        = 1'b0;
        store      = '0;
        rd_req     = '0;
        pool_start = 1'b0;
        rng        = 32'h0c74a09e;
        for (int c = 0; c < NUM_CH; c++)
        begin
            model_rd[c] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b1;
        check_flags(1'b0, 1'b0, "after reset");
        check_rd();

        for (int ch = 0; ch < NUM_CH; ch++)
        begin
            for (int a = 0; a < MAP_SIZE; a++)
            begin
                do_store(ch, a);
            end
        end
        for (int a = 0; a < N_SWEEP; a++)
        begin
            do_read('1, a, a + N_SWEEP);
        end
        repeat (N_RAND_RD) rand_read();

        run_pool();
        for (int k = 0; k < N_POOL_RD; k++)
        begin
            do_read('1, k, k + N_POOL_RD);
        end
        repeat (N_RAND_RD) rand_read(); // pooled area and untouched tail.

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== project.f ====
rtl/fmap_geom_pkg.sv
rtl/act_types_pkg.sv
rtl/pool_ctrl.sv
rtl/pool_window_counter.sv
rtl/fmap_bank.sv
rtl/fmap_buffer.sv
dv/fmap_buffer_checker.sv
dv/fmap_buffer_tb.sv

// ==== rtl/act_types_pkg.sv ====
package act_types_pkg;

    typedef logic signed [7:0] act_t;

    typedef struct packed {
        logic                                     valid;
        logic [$clog2(fmap_geom_pkg::NUM_CH)-1:0] ch;
        logic [fmap_geom_pkg::ADDR_W-1:0]         addr;
        act_t                                     bias;
        act_t                                     value;
    } store_req_t;

    typedef struct packed {
        logic [fmap_geom_pkg::NUM_CH-1:0] load; // one bit per channel.
        logic [fmap_geom_pkg::ADDR_W-1:0] addr1;
        logic [fmap_geom_pkg::ADDR_W-1:0] addr2;
    } read_req_t;

    typedef struct packed {
        act_t data1;
        act_t data2;
    } rd_pair_t;

    // sum in nine bits, then clip to the int8 range.
    function automatic act_t sat_add(act_t a, act_t b);
        logic signed [8:0] sum;
        sum = 9'(a) + 9'(b);
        if (sum > 9'sd127)
        begin
            return 8'sd127;
        end
        else if (sum < -9'sd128)
        begin
            return -8'sd128;
        end
        return sum[7:0];
    endfunction

endpackage

// ==== rtl/fmap_bank.sv ====
`timescale 1ns/1ps

module fmap_bank #(
    parameter int CH_IDX = 0
) (
    input  logic                             clk,
    input  logic                             rst,
    input  act_types_pkg::store_req_t        store,
    input  act_types_pkg::read_req_t         rd_req,
    input  logic                             pool_en,
    input  logic [fmap_geom_pkg::ADDR_W-1:0] win_base,
    input  logic [fmap_geom_pkg::ADDR_W-1:0] dst_addr,
    output act_types_pkg::rd_pair_t          rd_data
);
    import fmap_geom_pkg::*;
    import act_types_pkg::*;

    act_t mem [MAP_SIZE];

    logic [ADDR_W-1:0] addr_01;
    logic [ADDR_W-1:0] addr_10;
    logic [ADDR_W-1:0] addr_11;

    act_t win_00;
    act_t win_01;
    act_t win_10;
    act_t win_11;
    act_t max_top;
    act_t max_bot;
    act_t max_all;
    act_t pooled;

    logic store_hit;
    logic load_hit;

    // pooling owns the bank while it runs.
    assign store_hit = store.valid && (int'(store.ch) == CH_IDX) && !pool_en;
    assign load_hit  = rd_req.load[CH_IDX] && !pool_en;

    // 2x2 window neighbours.
    assign addr_01 = win_base + ADDR_W'(1);
    assign addr_10 = win_base + ADDR_W'(MAP_W);
    assign addr_11 = win_base + ADDR_W'(MAP_W + 1);

    always_comb
    begin
        win_00 = mem[win_base];
        win_01 = mem[addr_01];
        win_10 = mem[addr_10];
        win_11 = mem[addr_11];

        max_top = (win_01 > win_00) ? win_01 : win_00;
        max_bot = (win_11 > win_10) ? win_11 : win_10;
        max_all = (max_bot > max_top) ? max_bot : max_top;

        pooled = max_all[7] ? '0 : max_all; // relu.
    end

    // destination never passes an unread window, so in place is safe.
    always_ff @(posedge clk)
    begin
        if (pool_en)
        begin
            mem[dst_addr] <= pooled;
        end
        else if (store_hit)
        begin
            mem[store.addr] <= sat_add(store.value, store.bias);
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            rd_data <= '0;
        end
        else if (load_hit)
        begin
            rd_data.data1 <= mem[rd_req.addr1];
            rd_data.data2 <= mem[rd_req.addr2];
        end
    end

endmodule

// ==== rtl/fmap_buffer.sv ====
`timescale 1ns/1ps

module fmap_buffer (
    input  logic                                                clk,
    input  logic                                                rst,
    input  act_types_pkg::store_req_t                           store,
    input  act_types_pkg::read_req_t                            rd_req,
    input  logic                                                pool_start,
    output act_types_pkg::rd_pair_t [fmap_geom_pkg::NUM_CH-1:0] rd_data,
    output logic                                                pool_busy,
    output logic                                                pool_done
);
    import fmap_geom_pkg::*;

    logic              pool_en;
    logic              last_win;
    logic [ADDR_W-1:0] win_base;
    logic [ADDR_W-1:0] dst_addr;

    pool_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .pool_start (pool_start),
        .last_win   (last_win),
        .pool_en    (pool_en),
        .pool_busy  (pool_busy),
        .pool_done  (pool_done)
    );

    pool_window_counter u_cnt (
        .clk      (clk),
        .rst      (rst),
        .pool_en  (pool_en),
        .win_base (win_base),
        .dst_addr (dst_addr),
        .last_win (last_win)
    );

    // all channels pool in lock step.
    for (genvar i = 0; i < NUM_CH; i++)
    begin : g_bank
        fmap_bank #(
            .CH_IDX (i)
        ) u_bank (
            .clk      (clk),
            .rst      (rst),
            .store    (store),
            .rd_req   (rd_req),
            .pool_en  (pool_en),
            .win_base (win_base),
            .dst_addr (dst_addr),
            .rd_data  (rd_data[i])
        );
    end

endmodule

// ==== rtl/fmap_geom_pkg.sv ====
package fmap_geom_pkg;

    // channel count of the layer-one output.
    localparam int NUM_CH = 8;

    // full convolution map, square.
    localparam int MAP_W    = 28;
    localparam int MAP_SIZE = MAP_W * MAP_W;

    // after 2x2 pooling.
    localparam int POOL_W    = MAP_W / 2;
    localparam int POOL_SIZE = POOL_W * POOL_W;

    localparam int ADDR_W = $clog2(MAP_SIZE); // 10 bits for 784 words.

endpackage

// ==== rtl/pool_ctrl.sv ====
`timescale 1ns/1ps

module pool_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic pool_start,
    input  logic last_win,
    output logic pool_en,
    output logic pool_busy,
    output logic pool_done
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } state_t;

    state_t state;
    state_t next_state;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= next_state;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
            begin
                if (pool_start) // start pulses elsewhere are dropped.
                begin
                    next_state = RUN;
                end
            end
            RUN:
            begin
                if (last_win)
                begin
                    next_state = DONE;
                end
            end
            DONE:
            begin
                next_state = IDLE; // done holds a single cycle.
            end
            default:
            begin
                next_state = IDLE;
            end
        endcase
    end

    // one window per cycle while running.
    assign pool_en   = (state == RUN);
    assign pool_busy = (state == RUN);
    assign pool_done = (state == DONE);

endmodule

// ==== rtl/pool_window_counter.sv ====
`timescale 1ns/1ps

module pool_window_counter (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             pool_en,
    output logic [fmap_geom_pkg::ADDR_W-1:0] win_base,
    output logic [fmap_geom_pkg::ADDR_W-1:0] dst_addr,
    output logic                             last_win
);
    import fmap_geom_pkg::*;

    logic [3:0] col; // window column, 0 to 13.

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            col      <= '0;
            win_base <= '0;
            dst_addr <= '0;
        end
        else if (!pool_en)
        begin
            // park at the first window between runs.
            col      <= '0;
            win_base <= '0;
            dst_addr <= '0;
        end
        else
        begin
            dst_addr <= dst_addr + 1'b1;
            if (int'(col) == POOL_W - 1)
            begin
                col      <= '0;
                win_base <= win_base + ADDR_W'(MAP_W + 2); // skip the odd row.
            end
            else
            begin
                col      <= col + 1'b1;
                win_base <= win_base + ADDR_W'(2);
            end
        end
    end

    // compacted destination doubles as the window index.
    assign last_win = (int'(dst_addr) == POOL_SIZE - 1);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the feature-map buffer testbench with Verilator.
# The exit status is zero only when the pass line shows up in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal \
    --top-module fmap_buffer_tb \
    -f project.f \
    -o fmap_buffer_sim \
    && ./obj_dir/fmap_buffer_sim | tee /dev/stderr | grep -qF '*** PASSED ***' \
    && echo "simulation run passed" \
    || { echo "simulation run failed"; exit 1; }
